// ==== list.f ====
source/line_pkg.sv
source/bram.sv
source/scan_timer.sv
source/bank_ctrl.sv
source/pixel_out.sv
source/line_buffer_top.sv
test/line_buffer_assertions.sv
test/line_buffer_tb.sv

// ==== source/bank_ctrl.sv ====
// bank handover controller
`timescale 1ns/1ps

module bank_ctrl (
    input  logic                  rclk,
    input  logic                  rst_n,
    input  logic                  line_start,
    input  logic                  wr_done,
    output logic                  wr_bank,
    output logic                  rd_bank,
    output logic                  line_valid,
    output logic                  underrun,
    output logic                  wr_ready,
    output line_pkg::bank_state_t state
);
    logic take;          // a full bank moves to the reader in this cycle
    logic rd_bank_q;
    logic line_valid_q;

    // the handover looks at the state before any done pulse of this cycle
    assign take     = line_start && (state == line_pkg::full);
    assign underrun = line_start && (state != line_pkg::full);
    assign wr_ready = state == line_pkg::filling;

    // the reader addresses column 0 in the line start cycle itself,
    // so bank and validity of the new line are presented right away
    assign rd_bank    = take ? wr_bank : rd_bank_q;
    assign line_valid = line_start ? take : line_valid_q;

    always_ff @(posedge rclk or negedge rst_n) begin
        if (!rst_n) begin
            state <= line_pkg::filling;
        end else begin
            unique case (state)
                line_pkg::filling: begin
                    if (wr_done) begin
                        state <= line_pkg::full;  // done is only seen while writable
                    end
                end
                line_pkg::full: begin
                    if (line_start) begin
                        state <= line_pkg::filling;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge rclk or negedge rst_n) begin
        if (!rst_n) begin
            wr_bank      <= 1'b0;
            rd_bank_q    <= 1'b1;
            line_valid_q <= 1'b0;
        end else begin
            if (line_start) begin
                line_valid_q <= take;  // held for the rest of the period
            end
            if (take) begin
                // the writer gets the bank the reader just finished
                rd_bank_q <= wr_bank;
                wr_bank   <= ~wr_bank;
            end
        end
    end

endmodule

// ==== source/bram.sv ====
// block RAM wrapper
`timescale 1ns/1ps

module bram_block #(
    parameter int read_after_write = 0,
    parameter int addr_width       = 8,
    parameter int data_width       = 16
) (
    input  logic [addr_width-1:0] waddr,
    input  logic [addr_width-1:0] raddr,
    input  logic [data_width-1:0] wdata,
    input  logic                  write_enable,
    input  logic                  wclk,
    input  logic                  rclk,
    output logic [data_width-1:0] rdata
);
    localparam int depth = 1 << addr_width;

    // FPGA flows take the zero contents as the power-up image
    logic [data_width-1:0] mem [depth] = '{default: '0};

    always_ff @(posedge wclk) begin
        if (write_enable) begin
            mem[waddr] <= wdata;
        end
    end

    generate
        if (read_after_write != 0) begin : g_addr_reg
            // registered address, so a word written at the same edge is seen
            logic [addr_width-1:0] raddr_q;

            always_ff @(posedge rclk) begin
                raddr_q <= raddr;
            end

            assign rdata = mem[raddr_q];
        end else begin : g_data_reg
            always_ff @(posedge rclk) begin
                rdata <= mem[raddr];  // old contents on a same-address write
            end
        end
    endgenerate

endmodule

module bram #(
    parameter int read_after_write = 0,
    parameter int blocks           = 1,   // each block adds one lane of width
    parameter int block_addr_width = 8,
    parameter int block_data_width = 16
) (
    input  logic                                 wclk,
    input  logic                                 rclk,
    input  logic [block_addr_width-1:0]          waddr,
    input  logic [block_addr_width-1:0]          raddr,
    input  logic [blocks*block_data_width-1:0]   wdata,
    input  logic [blocks-1:0]                    write_mask,
    output logic [blocks*block_data_width-1:0]   rdata
);
    // all lanes share one address, a clear mask bit leaves that lane untouched
    for (genvar i = 0; i < blocks; i++) begin : g_lane
        bram_block #(
            .read_after_write(read_after_write),
            .addr_width      (block_addr_width),
            .data_width      (block_data_width)
        ) u_block (
            .waddr       (waddr),
            .raddr       (raddr),
            .wdata       (wdata[i*block_data_width +: block_data_width]),
            .write_enable(write_mask[i]),
            .wclk        (wclk),
            .rclk        (rclk),
            .rdata       (rdata[i*block_data_width +: block_data_width])
        );
    end

endmodule

// ==== source/line_buffer_top.sv ====
// double-buffered scanline store
`timescale 1ns/1ps

module line_buffer_top #(
    parameter int blocks           = line_pkg::default_blocks,
    parameter int block_addr_width = line_pkg::default_block_addr_width,
    parameter int block_data_width = line_pkg::default_block_data_width,
    parameter int line_words       = line_pkg::default_line_words,
    parameter int blank_words      = line_pkg::default_blank_words,
    parameter int read_after_write = 0,
    localparam int data_width      = blocks * block_data_width,
    localparam int col_width       = $clog2(line_words + blank_words),
    localparam int rd_col_width    = block_addr_width - 1
) (
    input  logic                        rclk,
    input  logic                        rst_n,
    input  logic                        wr_en,
    input  logic [block_addr_width-2:0] wr_addr,
    input  logic [data_width-1:0]       wr_data,
    input  logic [blocks-1:0]           wr_mask,
    input  logic                        wr_done,
    output logic                        wr_ready,
    output logic [data_width-1:0]       pix_data,
    output logic                        pix_valid,
    output logic                        line_sync,
    output logic                        underrun
);
    logic [col_width-1:0]        col;
    logic                        active;
    logic                        line_start;
    logic                        wr_bank;
    logic                        rd_bank;
    logic                        line_valid;
    line_pkg::bank_state_t       state;
    logic [block_addr_width-1:0] raddr;
    logic [data_width-1:0]       rdata;

    // the writer always targets the bank the reader does not hold
    wire [block_addr_width-1:0] waddr = {wr_bank, wr_addr};

    // lanes only write while the producer strobes and the bank is open
    wire [blocks-1:0] wr_lanes = wr_mask & {blocks{wr_en & wr_ready}};

    // active columns stay below half the block depth, so this never drops a set bit
    wire [rd_col_width-1:0] rd_col = rd_col_width'(col);

    scan_timer #(
        .line_words (line_words),
        .blank_words(blank_words)
    ) u_scan_timer (
        .rclk      (rclk),
        .rst_n     (rst_n),
        .col       (col),
        .active    (active),
        .line_start(line_start)
    );

    bank_ctrl u_bank_ctrl (
        .rclk      (rclk),
        .rst_n     (rst_n),
        .line_start(line_start),
        .wr_done   (wr_done),
        .wr_bank   (wr_bank),
        .rd_bank   (rd_bank),
        .line_valid(line_valid),
        .underrun  (underrun),
        .wr_ready  (wr_ready),
        .state     (state)
    );

    // single clock design, both RAM ports run on rclk
    bram #(
        .read_after_write(read_after_write),
        .blocks          (blocks),
        .block_addr_width(block_addr_width),
        .block_data_width(block_data_width)
    ) u_bram (
        .wclk      (rclk),
        .rclk      (rclk),
        .waddr     (waddr),
        .raddr     (raddr),
        .wdata     (wr_data),
        .write_mask(wr_lanes),
        .rdata     (rdata)
    );

    pixel_out #(
        .blocks          (blocks),
        .block_addr_width(block_addr_width),
        .block_data_width(block_data_width)
    ) u_pixel_out (
        .rclk      (rclk),
        .rst_n     (rst_n),
        .col       (rd_col),
        .active    (active),
        .line_start(line_start),
        .rd_bank   (rd_bank),
        .line_valid(line_valid),
        .raddr     (raddr),
        .rdata     (rdata),
        .pix_data  (pix_data),
        .pix_valid (pix_valid),
        .line_sync (line_sync)
    );

endmodule

// ==== source/line_pkg.sv ====
// scanline buffer definitions
package line_pkg;

    // geometry defaults, the top level passes these down as parameters
    localparam int default_blocks           = 2;   // RAM blocks side by side
    localparam int default_block_addr_width = 6;   // top address bit picks the bank
    localparam int default_block_data_width = 16;  // lane width of one block

    // active words must fit into half of one block, which is one bank
    localparam int default_line_words  = 24;
    localparam int default_blank_words = 8;

    // state of the bank the writer currently owns
    //   filling  the writer may store words and close the line with a done pulse
    //   full     the line is complete and waits for the next line start
    typedef enum logic {
        filling = 1'b0,
        full    = 1'b1
    } bank_state_t;

endpackage

// ==== source/pixel_out.sv ====
// pixel output stage
`timescale 1ns/1ps

module pixel_out #(
    parameter int blocks           = line_pkg::default_blocks,
    parameter int block_addr_width = line_pkg::default_block_addr_width,
    parameter int block_data_width = line_pkg::default_block_data_width,
    localparam int data_width      = blocks * block_data_width
) (
    input  logic                        rclk,
    input  logic                        rst_n,
    input  logic [block_addr_width-2:0] col,
    input  logic                        active,
    input  logic                        line_start,
    input  logic                        rd_bank,
    input  logic                        line_valid,
    output logic [block_addr_width-1:0] raddr,
    input  logic [data_width-1:0]       rdata,
    output logic [data_width-1:0]       pix_data,
    output logic                        pix_valid,
    output logic                        line_sync
);
    logic active_d1;
    logic start_d1;
    logic valid_d1;

    assign raddr = {rd_bank, col};  // bank bit on top, column below

    // first stage lines up with the RAM read latency
    always_ff @(posedge rclk or negedge rst_n) begin
        if (!rst_n) begin
            active_d1 <= 1'b0;
            start_d1  <= 1'b0;
            valid_d1  <= 1'b0;
        end else begin
            active_d1 <= active;
            start_d1  <= line_start;
            valid_d1  <= line_valid;
        end
    end

    // second stage is the output register
    always_ff @(posedge rclk or negedge rst_n) begin
        if (!rst_n) begin
            pix_valid <= 1'b0;
            line_sync <= 1'b0;
        end else begin
            pix_valid <= active_d1;
            line_sync <= start_d1;
        end
    end

    // an underrun line and the blanking columns go out as zero words
    always_ff @(posedge rclk) begin
        pix_data <= (active_d1 && valid_d1) ? rdata : '0;
    end

endmodule

// ==== source/scan_timer.sv ====
// line scan timer
`timescale 1ns/1ps

module scan_timer #(
    parameter int line_words  = line_pkg::default_line_words,
    parameter int blank_words = line_pkg::default_blank_words,
    localparam int period     = line_words + blank_words,
    localparam int col_width  = $clog2(period)
) (
    input  logic                 rclk,
    input  logic                 rst_n,
    output logic [col_width-1:0] col,
    output logic                 active,
    output logic                 line_start
);
    logic last_col;

    // the period need not be a power of two, so the wrap is decoded
    assign last_col = col == col_width'(period - 1);

    always_ff @(posedge rclk or negedge rst_n) begin
        if (!rst_n) begin
            col <= '0;
        end else if (last_col) begin
            col <= '0;
        end else begin
            col <= col + col_width'(1);
        end
    end

    // active columns come first, blanking fills the rest of the period
    assign active = col < col_width'(line_words);

    // column 0 is the first cycle after reset release as well
    assign line_start = col == '0;

endmodule

// ==== test/line_buffer_assertions.sv ====
// scanline output timing checks
`timescale 1ns/1ps

module line_buffer_assertions #(
    parameter int line_words = line_pkg::default_line_words
) (
    input logic                  rclk,
    input logic                  rst_n,
    input logic                  pix_valid,
    input logic                  line_sync,
    input logic                  underrun,
    input logic                  wr_ready,
    input line_pkg::bank_state_t state
);
    int unsigned valid_run;  // consecutive pix_valid cycles before the current one
    logic        seen_sync;

    always_ff @(posedge rclk or negedge rst_n) begin
        if (!rst_n) begin
            valid_run <= 0;
            seen_sync <= 1'b0;
        end else begin
            valid_run <= pix_valid ? valid_run + 1 : 0;
            if (line_sync) begin
                seen_sync <= 1'b1;
            end
        end
    end

    valid_run_len: assert property (@(posedge rclk) disable iff (!rst_n)
        pix_valid |-> valid_run < line_words)
        else $error("pix_valid stayed high longer than %0d cycles", line_words);

    // the release edge still sees the underrun of the reset state, so rst_n is sampled too
    underrun_to_sync: assert property (@(posedge rclk) disable iff (!rst_n)
        (rst_n && underrun) |-> ##2 line_sync)
        else $error("underrun was not followed by line_sync two cycles later");

    // the writer only gets a bank back at a handover, one cycle before line_sync
    ready_after_handover: assert property (@(posedge rclk) disable iff (!rst_n)
        (state == line_pkg::full) ##1 wr_ready |-> ##1 line_sync)
        else $error("wr_ready returned without a bank handover");

    quiet_until_sync: assert property (@(posedge rclk) disable iff (!rst_n)
        (!seen_sync && !line_sync) |-> !pix_valid)
        else $error("pix_valid rose before the first line_sync");

endmodule

bind line_buffer_top line_buffer_assertions #(
    .line_words(line_words)
) u_assertions (
    .rclk     (rclk),
    .rst_n    (rst_n),
    .pix_valid(pix_valid),
    .line_sync(line_sync),
    .underrun (underrun),
    .wr_ready (wr_ready),
    .state    (state)
);

// ==== test/line_buffer_tb.sv ====
// scanline buffer testbench
`timescale 1ns/1ps

module line_buffer_tb;

    localparam int blocks      = line_pkg::default_blocks;
    localparam int lane_width  = line_pkg::default_block_data_width;
    localparam int data_width  = blocks * lane_width;
    localparam int addr_width  = line_pkg::default_block_addr_width;
    localparam int col_width   = addr_width - 1;
    localparam int line_words  = line_pkg::default_line_words;
    localparam int period      = line_words + line_pkg::default_blank_words;
    localparam int bank_depth  = 1 << col_width;
    localparam int num_rows    = 13;
    localparam logic [31:0] rng_seed = 32'h56e9_9762;

    typedef struct packed {
        logic              wr;            // write a line while this period is read out
        logic [blocks-1:0] mask;
        logic [31:0]       seed;
        logic              done;
        logic              blocked;       // write and done again once the bank is closed
        logic              exp_underrun;  // period starts without a full bank
    } row_t;

    logic                  rclk;
    logic                  rst_n;
    logic                  wr_en;
    logic [col_width-1:0]  wr_addr;
    logic [data_width-1:0] wr_data;
    logic [blocks-1:0]     wr_mask;
    logic                  wr_done;
    logic                  wr_ready;
    logic [data_width-1:0] pix_data;
    logic                  pix_valid;
    logic                  line_sync;
    logic                  underrun;

    row_t                  rows [num_rows];
    logic [data_width-1:0] shadow [2][bank_depth];  // both banks as the producer left them
    line_pkg::bank_state_t m_state;
    logic                  m_wr_bank;
    logic                  m_rd_bank;
    logic                  m_valid;
    logic [31:0]           rng;
    int                    word_errors;
    int                    pulse_errors;
    int                    other_errors;

    line_buffer_top DUT (
        .rclk     (rclk),
        .rst_n    (rst_n),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .wr_mask  (wr_mask),
        .wr_done  (wr_done),
        .wr_ready (wr_ready),
        .pix_data (pix_data),
        .pix_valid(pix_valid),
        .line_sync(line_sync),
        .underrun (underrun)
    );

    initial begin
        rclk = 1'b0;
        forever #5 rclk = ~rclk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic load_rows();
        //            wr    mask   seed           done  blocked underrun
        rows[0]  = '{1'b1, 2'b11, 32'h0000_0101, 1'b1, 1'b0, 1'b1};  // line after reset
        rows[1]  = '{1'b1, 2'b11, 32'h0000_0202, 1'b1, 1'b0, 1'b0};
        rows[2]  = '{1'b1, 2'b01, 32'h0000_0303, 1'b1, 1'b0, 1'b0};
        rows[3]  = '{1'b1, 2'b10, 32'h0000_0404, 1'b1, 1'b0, 1'b0};
        rows[4]  = '{1'b0, 2'b00, 32'h0000_0505, 1'b0, 1'b0, 1'b0};
        rows[5]  = '{1'b1, 2'b11, 32'h0000_0606, 1'b1, 1'b1, 1'b1};
        rows[6]  = '{1'b1, 2'b11, 32'h0000_0707, 1'b1, 1'b0, 1'b0};
        rows[7]  = '{1'b1, 2'b10, 32'h0000_0808, 1'b0, 1'b0, 1'b0};  // upper lane, left open
        rows[8]  = '{1'b1, 2'b01, 32'h0000_0909, 1'b1, 1'b1, 1'b1};
        rows[9]  = '{1'b0, 2'b00, 32'h0000_0a0a, 1'b0, 1'b0, 1'b0};
        rows[10] = '{1'b0, 2'b00, 32'h0000_0b0b, 1'b1, 1'b0, 1'b1};  // done without new words
        rows[11] = '{1'b0, 2'b00, 32'h0000_0c0c, 1'b0, 1'b0, 1'b0};
        rows[12] = '{1'b0, 2'b00, 32'h0000_0d0d, 1'b0, 1'b0, 1'b1};
    endtask

    task automatic reset_model();
        int b;
        int a;
        for (b = 0; b < 2; b++) begin
            for (a = 0; a < bank_depth; a++) begin
                shadow[b][a] = '0;  // RAM powers up cleared
            end
        end
        m_state   = line_pkg::filling;
        m_wr_bank = 1'b0;
        m_rd_bank = 1'b1;
        m_valid   = 1'b0;
    endtask

    // a full bank moves to the reader at the line start, otherwise the line underruns
    task automatic model_handover();
        if (m_state == line_pkg::full) begin
            m_rd_bank = m_wr_bank;
            m_wr_bank = ~m_wr_bank;
            m_state   = line_pkg::filling;
            m_valid   = 1'b1;
        end else begin
            m_valid = 1'b0;
        end
    endtask

    task automatic model_write(input int addr, input logic [data_width-1:0] data,
                               input logic [blocks-1:0] mask);
        int l;
        if (m_state == line_pkg::filling) begin
            for (l = 0; l < blocks; l++) begin
                if (mask[l]) begin
                    shadow[m_wr_bank][addr][l*lane_width +: lane_width] =
                        data[l*lane_width +: lane_width];
                end
            end
        end
    endtask

    task automatic model_done();
        if (m_state == line_pkg::filling) begin
            m_state = line_pkg::full;
        end
    endtask

    task automatic drive_write(input logic en, input logic [col_width-1:0] addr,
                               input logic [data_width-1:0] data,
                               input logic [blocks-1:0] mask, input logic done);
        wr_en   <= en;
        wr_addr <= addr;
        wr_data <= data;
        wr_mask <= mask;
        wr_done <= done;
    endtask

    task automatic check_word(input logic [data_width-1:0] got,
                              input logic [data_width-1:0] exp, input string what);
        if (got !== exp) begin
            word_errors++;
            $display("[FAIL] %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_pulse(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            pulse_errors++;
            $display("[FAIL] %0d ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // stops on the cycle with line_sync high, underrun two samples earlier is returned
    task automatic wait_line_sync(output logic start_underrun, output logic found);
        logic [1:0] hist;
        int         n;
        hist  = 2'b00;
        found = 1'b0;
        for (n = 0; n < period + 4; n++) begin
            @(negedge rclk);
            if (line_sync === 1'b1) begin
                found = 1'b1;
                break;
            end
            hist = {hist[0], underrun};
        end
        start_underrun = hist[1];
        if (!found) begin
            other_errors++;
            $display("line_sync did not arrive within %0d cycles", period + 4);
        end
    endtask

    task automatic wait_write_ready(output logic found);
        int n;
        found = 1'b0;
        for (n = 0; n < 4; n++) begin
            if (wr_ready === 1'b1) begin
                found = 1'b1;
                break;
            end
            @(negedge rclk);
        end
        if (!found) begin
            other_errors++;
            $display("wr_ready stayed low for 4 cycles after line_sync");
        end
    endtask

    // one line period, entered at the line_sync cycle
    task automatic run_row(input int r, input logic start_underrun);
        int                    i;
        int                    j;
        logic [data_width-1:0] word;
        logic [data_width-1:0] exp;
        row_t                  row;
        row = rows[r];
        model_handover();
        check_pulse(start_underrun, row.exp_underrun, $sformatf("row %0d underrun", r));
        if (m_valid == row.exp_underrun) begin
            other_errors++;
            $display("row %0d: the table and the bank model disagree on the line validity", r);
        end
        rng = rng_seed ^ row.seed;
        for (i = 0; i < line_words; i++) begin
            exp = m_valid ? shadow[m_rd_bank][i] : '0;
            check_pulse(pix_valid, 1'b1, $sformatf("row %0d pix_valid at word %0d", r, i));
            check_pulse(line_sync, i == 0, $sformatf("row %0d line_sync at word %0d", r, i));
            check_word(pix_data, exp, $sformatf("row %0d word %0d", r, i));
            rng  = xorshift32(rng);
            word = data_width'(rng);
            @(posedge rclk);
            drive_write(row.wr, col_width'(i), word, row.mask, 1'b0);
            if (row.wr) begin
                model_write(i, word, row.mask);
            end
            @(negedge rclk);
        end
        check_pulse(pix_valid, 1'b0, $sformatf("row %0d pix_valid after the line", r));
        check_word(pix_data, '0, $sformatf("row %0d first blanking word", r));
        @(posedge rclk);
        drive_write(1'b0, '0, '0, '0, row.done);
        if (row.done) begin
            model_done();
        end
        for (j = 0; j < 2; j++) begin
            rng  = xorshift32(rng);
            word = ~data_width'(rng);  // junk that must never reach the output
            @(posedge rclk);
            drive_write(row.blocked, col_width'(j), word, '1, row.blocked);
            @(negedge rclk);
            check_pulse(wr_ready, m_state == line_pkg::filling,
                        $sformatf("row %0d wr_ready in closing cycle %0d", r, j));
            if (row.blocked) begin
                model_write(j, word, '1);
                model_done();
            end
        end
        @(posedge rclk);
        drive_write(1'b0, '0, '0, '0, 1'b0);
    endtask

    initial begin
        int   r;
        logic start_underrun;
        logic found;
        word_errors  = 0;
        pulse_errors = 0;
        other_errors = 0;
        rst_n   = 1'b0;
        wr_en   = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        wr_mask = '0;
        wr_done = 1'b0;
        load_rows();
        reset_model();
        repeat (2) @(posedge rclk);
        rst_n <= 1'b1;
        found = 1'b1;
        for (r = 0; r < num_rows && found; r++) begin
            wait_line_sync(start_underrun, found);
            if (found) begin
                wait_write_ready(found);
            end
            if (found) begin
                run_row(r, start_underrun);
            end
        end
        $display("errors: %0d word, %0d pulse, %0d other",
                 word_errors, pulse_errors, other_errors);
        if (word_errors + pulse_errors + other_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
